/* verif/mo_io_stim.txt */
# name sel ack_delay nbytes b0..b7 | cfg joy_a joy_b download core_reset load_err cart nwrites addr
# sel 0 config select, 1 download select, 2 reset pulse; ack_delay -1 is random
reset        2   0 0 00 00 00 00 00 00 00 00 040 00 00 0 0 0 0 0 0000
status_full  0   0 5 1E C0 13 00 00 00 00 00 1B4 00 00 0 0 0 0 0 0000
status_short 0   0 3 1E 00 04 00 00 00 00 00 1B4 00 00 0 0 0 0 0 0000
status_keys  0   0 5 1E 60 0C 00 00 00 00 00 00A 00 00 0 0 0 0 0 0000
joy0         0   0 2 02 5A 00 00 00 00 00 00 00A 5A 00 0 0 0 0 0 0000
joy1         0   0 2 03 A5 00 00 00 00 00 00 00A 5A A5 0 0 0 0 0 0000
status_swap  0   0 5 1E 08 00 00 00 00 00 00 041 A5 5A 0 0 0 0 0 0000
status_clear 0   0 5 1E 00 00 00 00 00 00 00 040 5A A5 0 0 0 0 0 0000
rom_index    1   0 2 55 00 00 00 00 00 00 00 040 5A A5 0 0 0 0 0 0000
rom_start    1   0 2 53 FF 00 00 00 00 00 00 040 5A A5 1 1 0 0 0 0000
rom_data     1   3 5 54 11 22 33 44 00 00 00 040 5A A5 1 1 0 0 4 C000
rom_end      1   0 2 53 00 00 00 00 00 00 00 040 5A A5 0 0 0 0 0 0000
cart_index   1   0 2 55 01 00 00 00 00 00 00 040 5A A5 0 0 0 0 0 0000
cart_start   1   0 2 53 FF 00 00 00 00 00 00 040 5A A5 1 1 0 1 0 0000
cart_data    1  -1 4 54 A1 B2 C3 00 00 00 00 040 5A A5 1 1 0 1 3 0000
cart_end     1   0 2 53 00 00 00 00 00 00 00 040 5A A5 0 0 0 1 0 0000
eject        0   0 5 1E 02 00 00 00 00 00 00 040 5A A5 0 0 0 0 0 0000
ovr_index    1   0 2 55 00 00 00 00 00 00 00 040 5A A5 0 0 0 0 0 0000
ovr_start    1   0 2 53 FF 00 00 00 00 00 00 040 5A A5 1 1 0 0 0 0000
ovr_data     1 120 3 54 E1 E2 00 00 00 00 00 040 5A A5 1 1 1 0 1 C000
ovr_end      1   0 2 53 00 00 00 00 00 00 00 040 5A A5 0 0 1 0 0 0000
restart      1   0 2 53 FF 00 00 00 00 00 00 040 5A A5 1 1 0 0 0 0000
restart_end  1   0 2 53 00 00 00 00 00 00 00 040 5A A5 0 0 0 0 0 0000

/* flist.f */
verilog/mo_io_pkg.sv
verilog/spi_byte_rx.sv
verilog/user_io.sv
verilog/data_io.sv
verilog/rom_loader.sv
verilog/mo_io_top.sv
verif/tb_clock.sv
verif/mo_io_properties.sv
verif/mo_io_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the mo_io testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module mo_io_tb \
    -f flist.f \
    -o mo_io_sim

sim_out=$(./obj_dir/mo_io_sim || true)
echo "$sim_out"

if echo "$sim_out" | grep -qx "Result: PASSED"; then
    exit 0
fi
exit 1

/* verif/mo_io_tb.sv */
module mo_io_tb;

    import mo_io_pkg::*;

    localparam int SCK_HALF     = 5;
    localparam int RST_CYCLES   = 5;
    localparam int IDLE_TIMEOUT = 600;
    localparam int RAND_DELAY   = 20;

    logic       clk_sys;
    logic       rst_n;
    logic       spi_sck;
    logic       spi_di;
    logic       spi_ss_io;
    logic       spi_ss_data;
    logic       mem_ack = 1'b0;
    mem_req_t   mem;
    mo_cfg_t    cfg;
    logic [7:0] joy_a;
    logic [7:0] joy_b;
    logic       core_reset;
    logic       download;
    logic       load_err;
    logic       cart_present;

    logic [7:0] mem_model [logic [15:0]];
    logic [7:0] frame_bytes [8];
    int         wr_count   = 0;
    int         ack_delay  = 0;
    int         resp_state = 0;
    int         resp_cnt   = 0;
    int         errors     = 0;
    int         tests_ok   = 0;
    int         tests_bad  = 0;
    bit         timed_out  = 1'b0;
    int         fd;
    int         num;
    string      line;

    tb_clock #(.PERIOD(4)) u_clock (.clk(clk_sys));

    mo_io_top #(
        .ROM_BASE  (16'hC000),
        .CART_BASE (16'h0000)
    ) DUT (
        .clk_sys      (clk_sys),
        .rst_n        (rst_n),
        .spi_sck      (spi_sck),
        .spi_di       (spi_di),
        .spi_ss_io    (spi_ss_io),
        .spi_ss_data  (spi_ss_data),
        .mem_ack      (mem_ack),
        .mem          (mem),
        .cfg          (cfg),
        .joy_a        (joy_a),
        .joy_b        (joy_b),
        .core_reset   (core_reset),
        .download     (download),
        .load_err     (load_err),
        .cart_present (cart_present)
    );

    // memory model acks after a delay and releases once req is gone
    always @(negedge clk_sys) begin
        if (!rst_n) begin
            mem_ack    = 1'b0;
            resp_state = 0;
        end else begin
            case (resp_state)
                0: begin
                    if (mem.req) begin
                        resp_cnt   = (ack_delay < 0) ? int'($urandom_range(RAND_DELAY, 0))
                                                     : ack_delay;
                        resp_state = 1;
                    end
                end
                1: begin
                    if (resp_cnt > 0) begin
                        resp_cnt--;
                    end else begin
                        mem_model[mem.addr] = mem.data;
                        wr_count++;
                        mem_ack    = 1'b1;
                        resp_state = 2;
                    end
                end
                default: begin
                    if (!mem.req) begin
                        mem_ack    = 1'b0;
                        resp_state = 0;
                    end
                end
            endcase
        end
    end

    task automatic check_val(input string sig, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Fail at %0t: %0s got %h expected %h", $time, sig, got, exp);
            errors++;
        end
    endtask

    task automatic set_select(input int sel, input logic level);
        if (sel == 0) begin
            spi_ss_io = level;
        end else begin
            spi_ss_data = level;
        end
    endtask

    // msb first and sampled by the DUT on the rising sck
    task automatic send_byte(input logic [7:0] value);
        int i;
        for (i = 7; i >= 0; i--) begin
            spi_di = value[i];
            repeat (SCK_HALF) @(negedge clk_sys);
            spi_sck = 1'b1;
            repeat (SCK_HALF) @(negedge clk_sys);
            spi_sck = 1'b0;
        end
    endtask

    task automatic send_frame(input int sel, input int n);
        int i;
        @(negedge clk_sys);
        set_select(sel, 1'b0);
        repeat (SCK_HALF) @(negedge clk_sys);
        for (i = 0; i < n; i++) begin
            send_byte(frame_bytes[i]);
        end
        repeat (8) @(negedge clk_sys);
        set_select(sel, 1'b1);
        repeat (8) @(negedge clk_sys);
    endtask

    task automatic pulse_reset();
        @(negedge clk_sys);
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(negedge clk_sys);
        rst_n = 1'b1;
        repeat (2) @(negedge clk_sys);
    endtask

    // sample half way through the low phase
    task automatic wait_port_idle();
        int cnt;
        cnt = 0;
        @(negedge clk_sys);
        #1;
        while ((mem.req || mem_ack || resp_state != 0) && cnt < IDLE_TIMEOUT) begin
            @(negedge clk_sys);
            #1;
            cnt++;
        end
        if (mem.req || mem_ack || resp_state != 0) begin
            $display("Timeout: memory port still busy after %0d cycles", IDLE_TIMEOUT);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic run_line(input string text, input int idx);
        int              fields;
        int              sel;
        int              n;
        int              e_dl;
        int              e_rst;
        int              e_err;
        int              e_cart;
        int              e_nwr;
        int              k;
        int              err_before;
        int              wr_before;
        logic [8:0]      e_cfg;
        logic [7:0]      e_ja;
        logic [7:0]      e_jb;
        logic [15:0]     e_addr;
        logic [15:0]     a;
        logic [8*16-1:0] name;

        err_before = errors;
        fields = $sscanf(text, "%s %d %d %d %h %h %h %h %h %h %h %h %h %h %h %d %d %d %d %d %h",
                         name, sel, ack_delay, n,
                         frame_bytes[0], frame_bytes[1], frame_bytes[2], frame_bytes[3],
                         frame_bytes[4], frame_bytes[5], frame_bytes[6], frame_bytes[7],
                         e_cfg, e_ja, e_jb, e_dl, e_rst, e_err, e_cart, e_nwr, e_addr);
        if (fields != 21) begin
            $display("Stim line %0d is malformed, only %0d fields read", idx, fields);
            errors++;
            tests_bad++;
            return;
        end
        wr_before = wr_count;
        if (sel == 2) begin
            pulse_reset();
        end else begin
            send_frame(sel, n);
        end
        wait_port_idle();

        check_val("cfg", 32'(cfg), 32'(e_cfg));
        check_val("joy_a", 32'(joy_a), 32'(e_ja));
        check_val("joy_b", 32'(joy_b), 32'(e_jb));
        check_val("download", 32'(download), e_dl);
        check_val("core_reset", 32'(core_reset), e_rst);
        check_val("load_err", 32'(load_err), e_err);
        check_val("cart_present", 32'(cart_present), e_cart);
        check_val("write count", wr_count - wr_before, e_nwr);

        // payload byte k+1 lands at the expected base plus k
        if (sel == 1 && frame_bytes[0] == 8'h54) begin
            for (k = 0; k < e_nwr; k++) begin
                a = e_addr + 16'(k);
                assert (mem_model.exists(a)) else begin
                    $display("No memory write seen at address %h in test %0d", a, idx);
                    errors++;
                end
                if (mem_model.exists(a)) begin
                    check_val($sformatf("mem[%h]", a), 32'(mem_model[a]),
                              32'(frame_bytes[k + 1]));
                end
            end
        end

        if (errors == err_before) begin
            tests_ok++;
            $display("test %0d %0s: ok", idx, name);
        end else begin
            tests_bad++;
            $display("test %0d %0s: %0d check(s) wrong", idx, name, errors - err_before);
        end
    endtask

    initial begin
        void'($urandom(32'hff4d));
        rst_n       = 1'b0;
        spi_sck     = 1'b0;
        spi_di      = 1'b0;
        spi_ss_io   = 1'b1;
        spi_ss_data = 1'b1;
        num         = 0;
        repeat (RST_CYCLES) @(negedge clk_sys);
        rst_n = 1'b1;
        repeat (2) @(negedge clk_sys);

        fd = $fopen("verif/mo_io_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open verif/mo_io_stim.txt");
            errors++;
        end else begin
            while (!$feof(fd) && !timed_out) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin
                    num++;
                    run_line(line, num);
                end
            end
            $fclose(fd);
        end

        $display("tests: %0d passed, %0d failed, %0d errors", tests_ok, tests_bad, errors);
        if (errors == 0 && tests_bad == 0 && tests_ok > 0 && !timed_out) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* verif/mo_io_properties.sv */
module mo_io_properties (
    input logic                clk_sys,
    input logic                rst_n,
    input mo_io_pkg::mem_req_t mem,
    input logic                mem_ack
);

    // request held until the memory answers
    req_until_ack: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        mem.req && !mem_ack |=> mem.req
    ) else $error("mem.req dropped before mem_ack rose");

    addr_data_stable: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        mem.req && $past(mem.req) |-> $stable(mem.addr) && $stable(mem.data)
    ) else $error("mem.addr or mem.data changed while mem.req was high");

    // next request only once ack is back low
    no_req_during_ack: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        $rose(mem.req) |-> !$past(mem_ack)
    ) else $error("mem.req rose while mem_ack was still high");

    req_low_after_reset: assert property (
        @(posedge clk_sys)
        !rst_n |=> !mem.req
    ) else $error("mem.req high in the cycle after reset");

endmodule

bind mo_io_top mo_io_properties u_properties (
    .clk_sys (clk_sys),
    .rst_n   (rst_n),
    .mem     (mem),
    .mem_ack (mem_ack)
);

/* verif/tb_clock.sv */
module tb_clock #(
    parameter int PERIOD = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

/* verilog/mo_io_top.sv */
module mo_io_top #(
    parameter logic [mo_io_pkg::MEM_AW-1:0] ROM_BASE  = 16'hC000,
    parameter logic [mo_io_pkg::MEM_AW-1:0] CART_BASE = 16'h0000
) (
    input  logic                clk_sys,
    input  logic                rst_n,
    input  logic                spi_sck,
    input  logic                spi_di,
    input  logic                spi_ss_io,
    input  logic                spi_ss_data,
    input  logic                mem_ack,
    output mo_io_pkg::mem_req_t mem,
    output mo_io_pkg::mo_cfg_t  cfg,
    output logic [7:0]          joy_a,
    output logic [7:0]          joy_b,
    output logic                core_reset,
    output logic                download,
    output logic                load_err,
    output logic                cart_present
);

    import mo_io_pkg::*;

    logic                io_valid;
    logic [7:0]          io_byte;
    logic                io_active;
    logic                dl_valid;
    logic [7:0]          dl_byte;
    logic                dl_active;
    logic [STATUS_W-1:0] status;
    logic [7:0]          joy0;
    logic [7:0]          joy1;
    ioctl_t              ioctl;

    // configuration channel
    spi_byte_rx u_spi_io (
        .clk_sys      (clk_sys),
        .rst_n        (rst_n),
        .sck          (spi_sck),
        .ss_n         (spi_ss_io),
        .di           (spi_di),
        .byte_valid   (io_valid),
        .rx_byte      (io_byte),
        .frame_active (io_active)
    );

    // download channel
    spi_byte_rx u_spi_data (
        .clk_sys      (clk_sys),
        .rst_n        (rst_n),
        .sck          (spi_sck),
        .ss_n         (spi_ss_data),
        .di           (spi_di),
        .byte_valid   (dl_valid),
        .rx_byte      (dl_byte),
        .frame_active (dl_active)
    );

    user_io u_user_io (
        .clk_sys      (clk_sys),
        .rst_n        (rst_n),
        .byte_valid   (io_valid),
        .rx_byte      (io_byte),
        .frame_active (io_active),
        .status       (status),
        .joy0         (joy0),
        .joy1         (joy1)
    );

    data_io u_data_io (
        .clk_sys      (clk_sys),
        .rst_n        (rst_n),
        .byte_valid   (dl_valid),
        .rx_byte      (dl_byte),
        .frame_active (dl_active),
        .ioctl        (ioctl)
    );

    rom_loader #(
        .ROM_BASE  (ROM_BASE),
        .CART_BASE (CART_BASE)
    ) u_rom_loader (
        .clk_sys      (clk_sys),
        .rst_n        (rst_n),
        .ioctl        (ioctl),
        .eject        (status[1]),
        .mem_ack      (mem_ack),
        .mem          (mem),
        .load_err     (load_err),
        .cart_present (cart_present)
    );

    // keyboard layout from bits 6:5, 00 is the dcmoto map
    always_comb begin
        cfg.mo5       = status[8];
        cfg.azerty    = status[6] & ~status[5];
        cfg.dcmoto    = ~status[5] & ~status[6];
        cfg.ovo_ena   = status[7];
        cfg.fast      = status[9];
        cfg.rewind    = status[10];
        cfg.scanlines = status[12:11];
        cfg.joy_swap  = status[3];
    end

    assign joy_a    = cfg.joy_swap ? joy1 : joy0;
    assign joy_b    = cfg.joy_swap ? joy0 : joy1;
    assign download = ioctl.download;

    // core held in reset by the reset option or a running download
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            core_reset <= 1'b1;
        end else begin
            core_reset <= status[0] | ioctl.download;
        end
    end

endmodule

/* verilog/rom_loader.sv */
module rom_loader #(
    parameter logic [mo_io_pkg::MEM_AW-1:0] ROM_BASE  = 16'hC000,
    parameter logic [mo_io_pkg::MEM_AW-1:0] CART_BASE = 16'h0000
) (
    input  logic                clk_sys,
    input  logic                rst_n,
    input  mo_io_pkg::ioctl_t   ioctl,
    input  logic                eject,
    input  logic                mem_ack,
    output mo_io_pkg::mem_req_t mem,
    output logic                load_err,
    output logic                cart_present
);

    import mo_io_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_ACK,
        ST_WAIT_RELEASE
    } ld_state_e;

    ld_state_e         state;
    logic              index_ok;
    logic              accept;
    logic [MEM_AW-1:0] base;
    logic              dl_prev;
    logic              eject_prev;

    // index 0 is the system ROM, odd indexes are cartridges
    always_comb begin
        index_ok = (ioctl.index == 8'd0) | ioctl.index[0];
        base     = ioctl.index[0] ? CART_BASE : ROM_BASE;
        accept   = ioctl.wr & ioctl.download & index_ok;
    end

    // four-phase write port
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            mem.req <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        mem.req  <= 1'b1;
                        mem.addr <= base + ioctl.addr[MEM_AW-1:0];
                        mem.data <= ioctl.dout;
                        state    <= ST_WAIT_ACK;
                    end
                end
                ST_WAIT_ACK: begin
                    if (mem_ack) begin
                        mem.req <= 1'b0;
                        state   <= ST_WAIT_RELEASE;
                    end
                end
                ST_WAIT_RELEASE: begin
                    if (!mem_ack) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            load_err     <= 1'b0;
            cart_present <= 1'b0;
            dl_prev      <= 1'b0;
            eject_prev   <= 1'b0;
        end else begin
            dl_prev    <= ioctl.download;
            eject_prev <= eject;
            if (eject & ~eject_prev) begin
                cart_present <= 1'b0;
            end
            if (ioctl.download & ~dl_prev) begin
                load_err <= 1'b0;
                if (ioctl.index[0]) begin
                    cart_present <= 1'b1;
                end
            end else if (accept && state != ST_IDLE) begin
                // byte dropped, port still busy
                load_err <= 1'b1;
            end
        end
    end

endmodule

/* verilog/data_io.sv */
module data_io (
    input  logic              clk_sys,
    input  logic              rst_n,
    input  logic              byte_valid,
    input  logic [7:0]        rx_byte,
    input  logic              frame_active,
    output mo_io_pkg::ioctl_t ioctl
);

    import mo_io_pkg::*;

    typedef enum logic {
        ST_OPCODE,
        ST_PAYLOAD
    } dio_state_e;

    dio_state_e          state;
    dio_op_e             opcode;
    logic                download_q;
    logic                wr_q;
    logic [7:0]          index_q;
    logic [IOCTL_AW-1:0] addr_q;
    logic [7:0]          dout_q;

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            state      <= ST_OPCODE;
            download_q <= 1'b0;
            wr_q       <= 1'b0;
            index_q    <= 8'd0;
            addr_q     <= '0;
        end else begin
            wr_q <= 1'b0;
            // offset moves on once the byte has gone out
            if (wr_q) begin
                addr_q <= addr_q + 1'b1;
            end
            if (!frame_active) begin
                state <= ST_OPCODE;
            end else if (byte_valid) begin
                if (state == ST_OPCODE) begin
                    opcode <= dio_op_e'(rx_byte);
                    state  <= ST_PAYLOAD;
                end else begin
                    case (opcode)
                        DIO_OP_INDEX: index_q <= rx_byte;
                        DIO_OP_CTRL: begin
                            if (rx_byte == 8'hFF) begin
                                download_q <= 1'b1;
                                addr_q     <= '0;
                            end else if (rx_byte == 8'h00) begin
                                download_q <= 1'b0;
                            end
                        end
                        DIO_OP_DATA: begin
                            wr_q   <= 1'b1;
                            dout_q <= rx_byte;
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

    assign ioctl = '{
        download: download_q,
        wr:       wr_q,
        index:    index_q,
        addr:     addr_q,
        dout:     dout_q
    };

endmodule

/* verilog/user_io.sv */
module user_io (
    input  logic                          clk_sys,
    input  logic                          rst_n,
    input  logic                          byte_valid,
    input  logic [7:0]                    rx_byte,
    input  logic                          frame_active,
    output logic [mo_io_pkg::STATUS_W-1:0] status,
    output logic [7:0]                    joy0,
    output logic [7:0]                    joy1
);

    import mo_io_pkg::*;

    localparam logic [2:0] STATUS_BYTES = 3'(STATUS_W / 8);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_OPCODE,
        ST_PAYLOAD
    } uio_state_e;

    uio_state_e            state;
    uio_op_e               opcode;
    logic [2:0]            byte_cnt;
    logic [STATUS_W-1:0]   shadow;

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            byte_cnt <= 3'd0;
            status   <= '0;
            joy0     <= 8'd0;
            joy1     <= 8'd0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (frame_active) begin
                        state <= ST_OPCODE;
                    end
                end
                ST_OPCODE: begin
                    if (!frame_active) begin
                        state <= ST_IDLE;
                    end else if (byte_valid) begin
                        opcode   <= uio_op_e'(rx_byte);
                        byte_cnt <= 3'd0;
                        state    <= ST_PAYLOAD;
                    end
                end
                ST_PAYLOAD: begin
                    if (!frame_active) begin
                        // commit only a complete status word
                        if (opcode == UIO_OP_STATUS && byte_cnt == STATUS_BYTES) begin
                            status <= shadow;
                        end
                        state <= ST_IDLE;
                    end else if (byte_valid) begin
                        if (byte_cnt != STATUS_BYTES) begin
                            byte_cnt <= byte_cnt + 3'd1;
                        end
                        case (opcode)
                            UIO_OP_STATUS: begin
                                // lsb first
                                if (byte_cnt != STATUS_BYTES) begin
                                    shadow[8*byte_cnt[1:0] +: 8] <= rx_byte;
                                end
                            end
                            UIO_OP_JOY0: if (byte_cnt == 3'd0) joy0 <= rx_byte;
                            UIO_OP_JOY1: if (byte_cnt == 3'd0) joy1 <= rx_byte;
                            default: ;
                        endcase
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

/* verilog/spi_byte_rx.sv */
module spi_byte_rx (
    input  logic       clk_sys,
    input  logic       rst_n,
    input  logic       sck,
    input  logic       ss_n,
    input  logic       di,
    output logic       byte_valid,
    output logic [7:0] rx_byte,
    output logic       frame_active
);

    logic [1:0] sck_sync;
    logic [1:0] ss_sync;
    logic [1:0] di_sync;
    logic       sck_prev;
    logic       ss_q;
    logic       bit_stb;
    logic       bit_val;
    logic [2:0] bit_cnt;
    logic [6:0] shift_reg;

    // two-flop synchronizers, then rising edge of sck
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            sck_sync <= 2'b00;
            ss_sync  <= 2'b11;
            sck_prev <= 1'b0;
            ss_q     <= 1'b1;
            bit_stb  <= 1'b0;
        end else begin
            sck_sync <= {sck_sync[0], sck};
            ss_sync  <= {ss_sync[0], ss_n};
            sck_prev <= sck_sync[1];
            ss_q     <= ss_sync[1];
            bit_stb  <= sck_sync[1] & ~sck_prev;
        end
    end

    // data line, same depth as sck
    always_ff @(posedge clk_sys) begin
        di_sync <= {di_sync[0], di};
        bit_val <= di_sync[1];
    end

    // bit count only runs while our select is low
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            bit_cnt      <= 3'd0;
            byte_valid   <= 1'b0;
            frame_active <= 1'b0;
        end else begin
            frame_active <= ~ss_q;
            byte_valid   <= bit_stb & ~ss_q & (bit_cnt == 3'd7);
            if (ss_q) begin
                bit_cnt <= 3'd0;
            end else if (bit_stb) begin
                bit_cnt <= bit_cnt + 3'd1;
            end
        end
    end

    // msb first
    always_ff @(posedge clk_sys) begin
        if (bit_stb) begin
            shift_reg <= {shift_reg[5:0], bit_val};
            if (bit_cnt == 3'd7) begin
                rx_byte <= {shift_reg, bit_val};
            end
        end
    end

endmodule

/* verilog/mo_io_pkg.sv */
package mo_io_pkg;

    localparam int unsigned STATUS_W = 32;
    localparam int unsigned MEM_AW   = 16;
    localparam int unsigned IOCTL_AW = 25;

    // user_io command bytes, first byte of a config frame
    typedef enum logic [7:0] {
        UIO_OP_JOY0   = 8'h02,
        UIO_OP_JOY1   = 8'h03,
        UIO_OP_STATUS = 8'h1E
    } uio_op_e;

    // data_io command bytes, first byte of a download frame
    typedef enum logic [7:0] {
        DIO_OP_CTRL  = 8'h53,
        DIO_OP_DATA  = 8'h54,
        DIO_OP_INDEX = 8'h55
    } dio_op_e;

    typedef struct packed {
        logic                download;
        logic                wr;
        logic [7:0]          index;
        logic [IOCTL_AW-1:0] addr;
        logic [7:0]          dout;
    } ioctl_t;

    // core options decoded from the status word
    typedef struct packed {
        logic       mo5;
        logic       azerty;
        logic       dcmoto;
        logic       ovo_ena;
        logic       fast;
        logic       rewind;
        logic [1:0] scanlines;
        logic       joy_swap;
    } mo_cfg_t;

    typedef struct packed {
        logic              req;
        logic [MEM_AW-1:0] addr;
        logic [7:0]        data;
    } mem_req_t;

endpackage
